/* core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Datapath widths
`define WORD_SIZE 32
`define REG_INDEX_SIZE 4
`define SPECREG_LENGTH 4 // N, Z, C, V from the high end

// Register numbers with a fixed role
`define PC_REGISTER 15
`define SP_REGISTER 14
`define LR_REGISTER 13
`define SYSCALL_REGISTER 7
`define SAVED_SP_REGISTER 5

// Memory map, in words
`define KERNEL_STACK 6143
`define USER_STACK 8191
`define OS_START 2048

`endif

/* isaPkg.sv */
package isaPkg;

    typedef enum logic [3:0] {
        opAdd     = 4'd0,
        opSub     = 4'd1,
        opAnd     = 4'd2,
        opOr      = 4'd3,
        opXor     = 4'd4,
        opMovi    = 4'd5,
        opLoad    = 4'd6,
        opStore   = 4'd7,
        opJumpz   = 4'd8,
        opSyscall = 4'd9,
        opSysret  = 4'd10,
        opCpxr    = 4'd11,
        opNop     = 4'd15 // Codes 12 to 14 behave the same
    } opcode_t;

    // Register bank write-back codes
    typedef enum logic [2:0] {
        ctlAdvance     = 3'd0,
        ctlWriteAlu    = 3'd1,
        ctlWriteMem    = 3'd3,
        ctlEnterPriv   = 3'd4,
        ctlExitPriv    = 3'd5,
        ctlCopySpecial = 3'd6
    } regControl_t;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluPassB
    } aluOp_t;

    typedef enum logic [2:0] {
        stFetch,
        stDecode,
        stExecute,
        stMemory,
        stWriteback
    } coreState_t;

endpackage

/* busPkg.sv */
package busPkg;

    // Wishbone master cycle state
    typedef enum logic {
        busIdle,
        busWaitAck
    } busState_t;

    // What the sequencer asks the bus for
    typedef enum logic [1:0] {
        reqFetch,
        reqLoad,
        reqStore
    } busRequest_t;

endpackage

/* regBank.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module regBank
    import isaPkg::*;
(
    input  logic                       fast_clock,
    input  logic                       reset,
    input  logic                       enable,
    input  regControl_t                control,
    input  logic [`REG_INDEX_SIZE-1:0] registerSourceA,
    input  logic [`REG_INDEX_SIZE-1:0] registerSourceB,
    input  logic [`REG_INDEX_SIZE-1:0] registerDest,
    input  logic [`WORD_SIZE-1:0]      aluResult,
    input  logic [`WORD_SIZE-1:0]      dataFromMemory,
    input  logic [`WORD_SIZE-1:0]      newPc,
    input  logic [`WORD_SIZE-1:0]      newSp,
    input  logic [`SPECREG_LENGTH-1:0] specialRegister,
    output logic [`WORD_SIZE-1:0]      readDataA,
    output logic [`WORD_SIZE-1:0]      readDataB,
    output logic [`WORD_SIZE-1:0]      currentPc,
    output logic [`WORD_SIZE-1:0]      currentSp,
    output logic [`WORD_SIZE-1:0]      memoryOutput
);

    localparam int kernelSpIndex = 16; // Hidden entry, not reachable by index

    logic [`WORD_SIZE-1:0] bank [0:16];
    logic                  destWritable;

    // SP and PC only change through the dedicated paths
    assign destWritable = (registerDest != `PC_REGISTER) && (registerDest != `SP_REGISTER);

    always_ff @(posedge fast_clock) begin
        readDataA    <= bank[registerSourceA];
        readDataB    <= bank[registerSourceB];
        currentPc    <= bank[`PC_REGISTER];
        currentSp    <= bank[`SP_REGISTER];
        memoryOutput <= bank[registerDest]; // Store data
    end

    always_ff @(posedge fast_clock) begin
        if (reset) begin
            bank[`SP_REGISTER]  <= `USER_STACK;
            bank[`PC_REGISTER]  <= '0;
            bank[kernelSpIndex] <= `KERNEL_STACK;
        end else if (enable) begin
            case (control)
                ctlWriteAlu: begin
                    if (destWritable) begin
                        bank[registerDest] <= aluResult;
                    end
                    bank[`PC_REGISTER] <= newPc;
                end
                ctlWriteMem: begin
                    if (destWritable) begin
                        bank[registerDest] <= dataFromMemory;
                    end
                    bank[`SP_REGISTER] <= newSp;
                    bank[`PC_REGISTER] <= newPc;
                end
                ctlEnterPriv: begin
                    bank[`SAVED_SP_REGISTER] <= bank[`SP_REGISTER];
                    bank[`LR_REGISTER]       <= newPc; // Return past the call
                    bank[`SP_REGISTER]       <= bank[kernelSpIndex];
                    bank[`PC_REGISTER]       <= `OS_START;
                    bank[`SYSCALL_REGISTER]  <= aluResult; // Call number
                end
                ctlExitPriv: begin
                    bank[kernelSpIndex]  <= bank[`SP_REGISTER];
                    bank[`SP_REGISTER]   <= bank[`SAVED_SP_REGISTER];
                    bank[`PC_REGISTER]   <= bank[`LR_REGISTER];
                end
                ctlCopySpecial: begin
                    if (destWritable) begin
                        bank[registerDest] <= {{(`WORD_SIZE-`SPECREG_LENGTH){1'b0}},
                                               specialRegister};
                    end
                    bank[`PC_REGISTER] <= newPc;
                end
                default: begin
                    bank[`SP_REGISTER] <= newSp;
                    bank[`PC_REGISTER] <= newPc;
                end
            endcase
        end
    end

    aControlDefined: assert property (@(posedge fast_clock) disable iff (reset)
        enable |-> control inside {ctlAdvance, ctlWriteAlu, ctlWriteMem,
                                   ctlEnterPriv, ctlExitPriv, ctlCopySpecial})
        else $error("Register bank written with undefined control code %0d", control);

    aEnablePulse: assert property (@(posedge fast_clock) disable iff (reset)
        enable |=> !enable)
        else $error("Register bank enable held longer than one cycle");

endmodule

/* aluUnit.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module aluUnit
    import isaPkg::*;
(
    input  logic                       fast_clock,
    input  logic                       reset,
    input  aluOp_t                     aluOp,
    input  logic [`WORD_SIZE-1:0]      operandA,
    input  logic [`WORD_SIZE-1:0]      operandB,
    input  logic                       updateFlags,
    output logic [`WORD_SIZE-1:0]      result,
    output logic [`SPECREG_LENGTH-1:0] flags
);

    logic [`WORD_SIZE:0]   wideResult; // Extra bit holds carry or borrow
    logic [`WORD_SIZE-1:0] nextResult;
    logic                  nextCarry;
    logic                  nextOverflow;

    assign nextResult = wideResult[`WORD_SIZE-1:0];

    always_comb begin
        nextCarry    = 1'b0;
        nextOverflow = 1'b0;
        case (aluOp)
            aluAdd: begin
                wideResult   = {1'b0, operandA} + {1'b0, operandB};
                nextCarry    = wideResult[`WORD_SIZE];
                nextOverflow = (operandA[`WORD_SIZE-1] == operandB[`WORD_SIZE-1]) &&
                               (wideResult[`WORD_SIZE-1] != operandA[`WORD_SIZE-1]);
            end
            aluSub: begin
                wideResult   = {1'b0, operandA} - {1'b0, operandB};
                nextCarry    = wideResult[`WORD_SIZE]; // Borrow
                nextOverflow = (operandA[`WORD_SIZE-1] != operandB[`WORD_SIZE-1]) &&
                               (wideResult[`WORD_SIZE-1] != operandA[`WORD_SIZE-1]);
            end
            aluAnd:  wideResult = {1'b0, operandA & operandB};
            aluOr:   wideResult = {1'b0, operandA | operandB};
            aluXor:  wideResult = {1'b0, operandA ^ operandB};
            default: wideResult = {1'b0, operandB}; // Pass B for movi and syscall
        endcase
    end

    always_ff @(posedge fast_clock) begin
        result <= nextResult;
    end

    always_ff @(posedge fast_clock) begin
        if (reset) begin
            flags <= '0;
        end else if (updateFlags) begin
            flags <= {nextResult[`WORD_SIZE-1], nextResult == '0, nextCarry, nextOverflow};
        end
    end

endmodule

/* instrDecoder.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module instrDecoder
    import isaPkg::*, busPkg::*;
(
    input  logic [`WORD_SIZE-1:0]      instruction,
    output opcode_t                    opcode,
    output logic [`REG_INDEX_SIZE-1:0] registerDest,
    output logic [`REG_INDEX_SIZE-1:0] registerSourceA,
    output logic [`REG_INDEX_SIZE-1:0] registerSourceB,
    output logic [`WORD_SIZE-1:0]      immediate,
    output aluOp_t                     aluOp,
    output logic                       useImmediate,
    output logic                       updateFlags,
    output regControl_t                control,
    output busRequest_t                memoryKind,
    output logic                       needsMemory
);

    assign opcode          = opcode_t'(instruction[31:28]);
    assign registerDest    = instruction[27:24];
    assign registerSourceA = instruction[23:20];
    assign registerSourceB = instruction[19:16];
    assign immediate       = {{(`WORD_SIZE-16){1'b0}}, instruction[15:0]};

    always_comb begin
        aluOp        = aluAdd;
        useImmediate = 1'b1;
        updateFlags  = 1'b0;
        control      = ctlAdvance; // Also covers jumpz, nop and unused codes
        memoryKind   = reqFetch;
        needsMemory  = 1'b0;
        case (opcode)
            opAdd, opSub, opAnd, opOr, opXor: begin
                useImmediate = 1'b0;
                updateFlags  = 1'b1;
                control      = ctlWriteAlu;
                case (opcode)
                    opSub:   aluOp = aluSub;
                    opAnd:   aluOp = aluAnd;
                    opOr:    aluOp = aluOr;
                    opXor:   aluOp = aluXor;
                    default: aluOp = aluAdd;
                endcase
            end
            opMovi: begin
                aluOp   = aluPassB;
                control = ctlWriteAlu;
            end
            opLoad: begin
                control     = ctlWriteMem; // Address is ra + imm
                memoryKind  = reqLoad;
                needsMemory = 1'b1;
            end
            opStore: begin
                memoryKind  = reqStore;
                needsMemory = 1'b1;
            end
            opSyscall: begin
                aluOp   = aluPassB; // Call number into register 7
                control = ctlEnterPriv;
            end
            opSysret: control = ctlExitPriv;
            opCpxr:   control = ctlCopySpecial;
            default:  control = ctlAdvance;
        endcase
    end

endmodule

/* busMaster.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module busMaster
    import busPkg::*;
(
    input  logic                  fast_clock,
    input  logic                  reset,
    input  logic                  busStart,
    input  busRequest_t           busKind,
    input  logic [`WORD_SIZE-1:0] busAddress,
    input  logic [`WORD_SIZE-1:0] busWriteData,
    output logic                  busDone,
    output logic [`WORD_SIZE-1:0] busReadData,
    output logic                  wbCyc,
    output logic                  wbStb,
    output logic                  wbWe,
    output logic [`WORD_SIZE-1:0] wbAdr,
    output logic [`WORD_SIZE-1:0] wbDatOut,
    input  logic [`WORD_SIZE-1:0] wbDatIn,
    input  logic                  wbAck
);

    busState_t state;

    always_ff @(posedge fast_clock) begin
        if (reset) begin
            state   <= busIdle;
            wbCyc   <= 1'b0;
            wbStb   <= 1'b0;
            wbWe    <= 1'b0;
            busDone <= 1'b0;
        end else begin
            busDone <= 1'b0;
            case (state)
                busIdle: if (busStart) begin
                    wbCyc <= 1'b1; // Cyc and Stb rise together
                    wbStb <= 1'b1;
                    wbWe  <= (busKind == reqStore);
                    state <= busWaitAck;
                end
                busWaitAck: if (wbAck) begin
                    wbCyc   <= 1'b0;
                    wbStb   <= 1'b0;
                    wbWe    <= 1'b0;
                    busDone <= 1'b1;
                    state   <= busIdle;
                end
                default: state <= busIdle;
            endcase
        end
    end

    always_ff @(posedge fast_clock) begin
        if (state == busIdle && busStart) begin
            wbAdr    <= busAddress; // Held until the acknowledge
            wbDatOut <= busWriteData;
        end
        if (state == busWaitAck && wbAck) begin
            busReadData <= wbDatIn;
        end
    end

    aStbNeedsCyc: assert property (@(posedge fast_clock) disable iff (reset)
        wbStb |-> wbCyc)
        else $error("Wishbone strobe without cycle");

    aAddressStable: assert property (@(posedge fast_clock) disable iff (reset)
        (wbStb && !wbAck) |=> $stable(wbAdr) && $stable(wbWe) && $stable(wbDatOut))
        else $error("Wishbone request changed before the acknowledge");

    aNoOverlap: assert property (@(posedge fast_clock) disable iff (reset)
        busStart |-> state == busIdle)
        else $error("Bus request while a cycle is in progress");

endmodule

/* coreSequencer.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module coreSequencer
    import isaPkg::*, busPkg::*;
(
    input  logic                       fast_clock,
    input  logic                       reset,
    input  logic                       busDone,
    input  logic [`WORD_SIZE-1:0]      busReadData,
    input  logic                       needsMemory,
    input  opcode_t                    opcode,
    input  logic [`SPECREG_LENGTH-1:0] flags,
    input  logic [`WORD_SIZE-1:0]      currentPc,
    input  logic [`WORD_SIZE-1:0]      aluResult,
    output logic                       busStart,
    output busRequest_t                busKind,
    output logic [`WORD_SIZE-1:0]      busAddress,
    output logic [`WORD_SIZE-1:0]      instruction,
    output logic                       bankEnable,
    output logic [`WORD_SIZE-1:0]      newPc
);

    coreState_t            state;
    logic                  issued; // Bus request already sent in this state
    logic [`WORD_SIZE-1:0] jumpTarget;

    assign jumpTarget = {{(`WORD_SIZE-16){1'b0}}, instruction[15:0]};
    assign newPc      = (opcode == opJumpz && flags[`SPECREG_LENGTH-2]) ? jumpTarget
                                                                        : currentPc + 32'd1;
    assign busAddress = (state == stMemory) ? aluResult : currentPc; // ALU adds ra + imm
    assign busKind    = (state != stMemory) ? reqFetch :
                        (opcode == opStore) ? reqStore : reqLoad;

    always_ff @(posedge fast_clock) begin
        if (reset) begin
            state       <= stFetch;
            issued      <= 1'b0;
            busStart    <= 1'b0;
            bankEnable  <= 1'b0;
            instruction <= {opNop, {(`WORD_SIZE-4){1'b0}}};
        end else begin
            busStart   <= 1'b0;
            bankEnable <= 1'b0;
            case (state)
                // One cycle of slack lets currentPc catch up with the last write-back
                stFetch, stMemory: begin
                    if (!issued) begin
                        busStart <= 1'b1;
                        issued   <= 1'b1;
                    end
                    if (busDone) begin
                        issued <= 1'b0;
                        if (state == stFetch) begin
                            instruction <= busReadData;
                            state       <= stDecode;
                        end else begin
                            bankEnable <= 1'b1;
                            state      <= stWriteback;
                        end
                    end
                end
                stDecode: state <= stExecute;
                stExecute: begin
                    if (needsMemory) begin
                        state <= stMemory;
                    end else begin
                        bankEnable <= 1'b1;
                        state      <= stWriteback;
                    end
                end
                stWriteback: begin
                    // Nop keeps the flags still until the next instruction arrives
                    instruction <= {opNop, {(`WORD_SIZE-4){1'b0}}};
                    state       <= stFetch;
                end
                default: state <= stFetch;
            endcase
        end
    end

    aWritebackOnly: assert property (@(posedge fast_clock) disable iff (reset)
        bankEnable |-> state == stWriteback)
        else $error("Register bank enabled outside write-back");

endmodule

/* cpuCore.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module cpuCore
    import isaPkg::*, busPkg::*;
(
    input  logic                  fast_clock,
    input  logic                  reset,
    output logic                  wbCyc,
    output logic                  wbStb,
    output logic                  wbWe,
    output logic [`WORD_SIZE-1:0] wbAdr,
    output logic [`WORD_SIZE-1:0] wbDatOut,
    input  logic [`WORD_SIZE-1:0] wbDatIn,
    input  logic                  wbAck
);

    logic [`WORD_SIZE-1:0]      instruction, immediate, operandB, aluResult;
    logic [`WORD_SIZE-1:0]      readDataA, readDataB, currentPc, currentSp;
    logic [`WORD_SIZE-1:0]      memoryOutput, newPc, busAddress, busReadData;
    logic [`REG_INDEX_SIZE-1:0] registerDest, registerSourceA, registerSourceB;
    logic [`SPECREG_LENGTH-1:0] flags;
    logic                       useImmediate, updateFlags, needsMemory;
    logic                       busStart, busDone, bankEnable;
    opcode_t                    opcode;
    aluOp_t                     aluOp;
    regControl_t                control;
    busRequest_t                memoryKind, busKind;

    assign operandB = useImmediate ? immediate : readDataB;

    instrDecoder i_instrDecoder (
        .instruction(instruction), .opcode(opcode), .registerDest(registerDest),
        .registerSourceA(registerSourceA), .registerSourceB(registerSourceB),
        .immediate(immediate), .aluOp(aluOp), .useImmediate(useImmediate),
        .updateFlags(updateFlags), .control(control), .memoryKind(memoryKind),
        .needsMemory(needsMemory)
    );

    regBank i_regBank (
        .fast_clock(fast_clock), .reset(reset), .enable(bankEnable), .control(control),
        .registerSourceA(registerSourceA), .registerSourceB(registerSourceB),
        .registerDest(registerDest), .aluResult(aluResult), .dataFromMemory(busReadData),
        .newPc(newPc), .newSp(currentSp), // Stack pointer left unchanged
        .specialRegister(flags), .readDataA(readDataA), .readDataB(readDataB),
        .currentPc(currentPc), .currentSp(currentSp), .memoryOutput(memoryOutput)
    );

    aluUnit i_aluUnit (
        .fast_clock(fast_clock), .reset(reset), .aluOp(aluOp), .operandA(readDataA),
        .operandB(operandB), .updateFlags(updateFlags), .result(aluResult), .flags(flags)
    );

    busMaster i_busMaster (
        .fast_clock(fast_clock), .reset(reset), .busStart(busStart), .busKind(busKind),
        .busAddress(busAddress), .busWriteData(memoryOutput), .busDone(busDone),
        .busReadData(busReadData), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
        .wbAdr(wbAdr), .wbDatOut(wbDatOut), .wbDatIn(wbDatIn), .wbAck(wbAck)
    );

    coreSequencer i_coreSequencer (
        .fast_clock(fast_clock), .reset(reset), .busDone(busDone),
        .busReadData(busReadData), .needsMemory(needsMemory), .opcode(opcode),
        .flags(flags), .currentPc(currentPc), .aluResult(aluResult), .busStart(busStart),
        .busKind(busKind), .busAddress(busAddress), .instruction(instruction),
        .bankEnable(bankEnable), .newPc(newPc)
    );

    // Data request kind from the sequencer agrees with the decoded instruction
    aKindMatches: assert property (@(posedge fast_clock) disable iff (reset)
        (busStart && busKind != reqFetch) |-> busKind == memoryKind)
        else $error("Data access kind differs from the decoded instruction");

endmodule

/* tbCpuCore.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module tbCpuCore
    import isaPkg::*;
();

    localparam int memoryBits  = 12;
    localparam int memoryDepth = 1 << memoryBits;
    localparam int storeBase   = 3000; // Result area
    localparam int dataAddress = 3100;
    localparam int syscallAt   = 32;
    localparam int cycleLimit  = 4000;
    localparam int stallLimit  = 40;
    localparam logic [31:0] valueA    = 32'h0000_1234;
    localparam logic [31:0] valueB    = 32'h0000_0F0F;
    localparam logic [31:0] tableWord = 32'hCAFE_F00D;

    logic                  fast_clock;
    logic                  reset;
    logic                  wbCyc, wbStb, wbWe, wbAck;
    logic [`WORD_SIZE-1:0] wbAdr, wbDatOut, wbDatIn;

    logic [31:0] memory [0:memoryDepth-1];
    logic [31:0] programAddress [$];
    logic [31:0] programWord [$];
    logic [31:0] storeAddress [$];
    logic [31:0] storeData [$];
    logic [31:0] fetchFrom [$]; // Fetch at this address...
    logic [31:0] fetchTo [$];   // ...must be followed by a fetch here
    logic [31:0] lfsr;
    logic [31:0] fetchExpected;
    logic [31:0] heldAddress;
    logic        fetchPending;
    logic        accessActive;
    int          waitLeft;
    int          valueErrors;
    int          protocolErrors;
    int          storesSeen;
    int          ackCount;

    cpuCore i_cpuCore (
        .fast_clock(fast_clock), .reset(reset), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
        .wbAdr(wbAdr), .wbDatOut(wbDatOut), .wbDatIn(wbDatIn), .wbAck(wbAck)
    );

    function automatic logic [31:0] encode(input opcode_t op, input int rd, input int ra,
                                           input int rb, input int imm);
        encode = {op, 4'(rd), 4'(ra), 4'(rb), 16'(imm)};
    endfunction

    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        if (state[0]) begin
            lfsrNext = (state >> 1) ^ 32'hD000_0001;
        end else begin
            lfsrNext = state >> 1;
        end
    endfunction

    task automatic drawWaitCycles(output int cycles);
        logic [1:0] bits;
        bits = 2'b00;
        repeat (2) begin
            bits = {bits[0], lfsr[0]}; // One LFSR step per bit
            lfsr = lfsrNext(lfsr);
        end
        cycles = int'(bits);
    endtask

    task automatic placeWord(input int address, input logic [31:0] word);
        programAddress.push_back(address);
        programWord.push_back(word);
    endtask

    task automatic expectStore(input int offset, input logic [31:0] data);
        storeAddress.push_back(storeBase + offset);
        storeData.push_back(data);
    endtask

    task automatic expectNextFetch(input int from, input int to);
        fetchFrom.push_back(from);
        fetchTo.push_back(to);
    endtask

    // Program listed in execution order, stores expected as they run
    task automatic buildTables();
        placeWord(0, encode(opMovi, 0, 0, 0, 0));
        placeWord(1, encode(opMovi, 1, 0, 0, valueA));
        placeWord(2, encode(opMovi, 2, 0, 0, valueB));
        placeWord(3, encode(opAdd, 3, 1, 2, 0));
        placeWord(4, encode(opStore, 3, 0, 0, storeBase));
        expectStore(0, valueA + valueB);
        placeWord(5, encode(opSub, 3, 1, 2, 0));
        placeWord(6, encode(opStore, 3, 0, 0, storeBase + 1));
        expectStore(1, valueA - valueB);
        placeWord(7, encode(opAnd, 3, 1, 2, 0));
        placeWord(8, encode(opStore, 3, 0, 0, storeBase + 2));
        expectStore(2, valueA & valueB);
        placeWord(9, encode(opOr, 3, 1, 2, 0));
        placeWord(10, encode(opStore, 3, 0, 0, storeBase + 3));
        expectStore(3, valueA | valueB);
        placeWord(11, encode(opXor, 3, 1, 2, 0));
        placeWord(12, encode(opStore, 3, 0, 0, storeBase + 4));
        expectStore(4, valueA ^ valueB);
        placeWord(13, encode(opLoad, 4, 0, 0, dataAddress));
        placeWord(14, encode(opStore, 4, 0, 0, storeBase + 5));
        expectStore(5, tableWord);
        placeWord(15, encode(opAdd, `PC_REGISTER, 1, 2, 0)); // Must not redirect
        expectNextFetch(15, 16);
        placeWord(16, encode(opAdd, `SP_REGISTER, 1, 2, 0));
        expectNextFetch(16, 17);
        placeWord(17, encode(opStore, `SP_REGISTER, 0, 0, storeBase + 6));
        expectStore(6, `USER_STACK);
        placeWord(18, encode(opSub, 8, 1, 1, 0)); // Zero result
        placeWord(19, encode(opCpxr, 6, 0, 0, 0));
        placeWord(20, encode(opStore, 6, 0, 0, storeBase + 7));
        expectStore(7, 32'b0100); // Only the zero flag set
        placeWord(21, encode(opJumpz, 0, 0, 0, 30)); // Taken
        expectNextFetch(21, 30);
        placeWord(30, encode(opSub, 8, 1, 2, 0));
        placeWord(31, encode(opJumpz, 0, 0, 0, 40)); // Not taken
        expectNextFetch(31, 32);
        placeWord(syscallAt, encode(opSyscall, 0, 0, 0, 9));
        expectNextFetch(syscallAt, `OS_START);
        placeWord(`OS_START, encode(opStore, `SYSCALL_REGISTER, 0, 0, storeBase + 8));
        expectStore(8, 9);
        placeWord(`OS_START + 1, encode(opStore, `LR_REGISTER, 0, 0, storeBase + 9));
        expectStore(9, syscallAt + 1);
        placeWord(`OS_START + 2, encode(opStore, `SP_REGISTER, 0, 0, storeBase + 10));
        expectStore(10, `KERNEL_STACK);
        placeWord(`OS_START + 3, encode(opSysret, 0, 0, 0, 0));
        expectNextFetch(`OS_START + 3, syscallAt + 1);
        placeWord(syscallAt + 1, encode(opStore, `SP_REGISTER, 0, 0, storeBase + 11));
        expectStore(11, `USER_STACK);
        placeWord(dataAddress, tableWord);
    endtask

    task automatic loadMemory();
        for (int i = 0; i < memoryDepth; i++) begin
            memory[i[memoryBits-1:0]] = {opNop, 28'(i)}; // Nop tagged with its address
        end
        foreach (programAddress[n]) begin
            memory[programAddress[n][memoryBits-1:0]] = programWord[n];
        end
    endtask

    task automatic checkStore();
        assert (storesSeen < storeAddress.size()) else begin
            protocolErrors++;
            $display("Unexpected extra store to word %0d", wbAdr);
        end
        if (storesSeen < storeAddress.size()) begin
            assert (wbAdr == storeAddress[storesSeen]) else begin
                valueErrors++;
                $display("** Error at %0t: store %0d went to word %0d, expected %0d",
                         $time, storesSeen, wbAdr, storeAddress[storesSeen]);
            end
            assert (wbDatOut == storeData[storesSeen]) else begin
                valueErrors++;
                $display("** Error at %0t: store %0d wrote %h, expected %h",
                         $time, storesSeen, wbDatOut, storeData[storesSeen]);
            end
        end
        storesSeen++;
    endtask

    task automatic checkFetchOrder();
        if (fetchPending) begin
            assert (wbAdr == fetchExpected) else begin
                valueErrors++;
                $display("** Error at %0t: fetch from word %0d, expected %0d",
                         $time, wbAdr, fetchExpected);
            end
            fetchPending = 1'b0;
        end
        foreach (fetchFrom[k]) begin
            if (fetchFrom[k] == wbAdr) begin
                fetchPending  = 1'b1;
                fetchExpected = fetchTo[k];
            end
        end
    endtask

    task automatic completeAccess();
        if (wbAdr >= memoryDepth) begin
            protocolErrors++;
            $display("Access outside the memory model at word %0d", wbAdr);
            wbDatIn = '0;
        end else if (wbWe) begin
            checkStore();
            memory[wbAdr[memoryBits-1:0]] = wbDatOut;
        end else begin
            checkFetchOrder(); // Loads pass through too
            wbDatIn = memory[wbAdr[memoryBits-1:0]];
        end
        wbAck = 1'b1;
        ackCount++;
    endtask

    task automatic serveBus();
        int cycles;
        if (wbAck) begin
            wbAck        = 1'b0; // Taken by the master on the last edge
            accessActive = 1'b0;
        end else if (wbCyc && wbStb) begin
            if (!accessActive) begin
                drawWaitCycles(cycles);
                waitLeft     = cycles;
                heldAddress  = wbAdr;
                accessActive = 1'b1;
            end else begin
                assert (wbAdr == heldAddress) else begin
                    protocolErrors++;
                    $display("Wishbone address moved from %0d to %0d before the acknowledge",
                             heldAddress, wbAdr);
                end
            end
            if (waitLeft == 0) begin
                completeAccess();
            end else begin
                waitLeft--;
            end
        end
    endtask

    task automatic waitForStores(output bit timedOut);
        int cycles;
        int idleCycles;
        int lastAcks;
        timedOut   = 1'b0;
        cycles     = 0;
        idleCycles = 0;
        lastAcks   = ackCount;
        while (storesSeen < storeAddress.size() && !timedOut) begin
            @(posedge fast_clock);
            cycles++;
            if (ackCount != lastAcks) begin
                idleCycles = 0;
                lastAcks   = ackCount;
            end else begin
                idleCycles++;
            end
            if (idleCycles > stallLimit) begin
                $display("Timeout: no Wishbone acknowledge for %0d cycles", stallLimit);
                timedOut = 1'b1;
            end else if (cycles > cycleLimit) begin
                $display("Timeout: only %0d of %0d stores seen after %0d cycles",
                         storesSeen, storeAddress.size(), cycleLimit);
                timedOut = 1'b1;
            end
        end
    endtask

    initial begin : clockGenerator
        fast_clock = 1'b0;
        forever #4 fast_clock = ~fast_clock;
    end

    initial begin : memoryModel
        forever begin
            @(posedge fast_clock);
            #1;
            serveBus();
        end
    end

    initial begin : mainSequence
        bit timedOut;
        reset          = 1'b1;
        wbAck          = 1'b0;
        wbDatIn        = '0;
        lfsr           = 32'h1811;
        fetchPending   = 1'b1; // First fetch after reset
        fetchExpected  = '0;
        heldAddress    = '0;
        accessActive   = 1'b0;
        waitLeft       = 0;
        valueErrors    = 0;
        protocolErrors = 0;
        storesSeen     = 0;
        ackCount       = 0;
        buildTables();
        loadMemory();
        repeat (3) begin
            @(posedge fast_clock);
            #1;
            assert (!wbCyc) else begin
                protocolErrors++;
                $display("Wishbone cycle active during reset");
            end
        end
        reset = 1'b0;
        waitForStores(timedOut);
        $display("Value errors: %0d, protocol errors: %0d, timeouts: %0d, stores: %0d of %0d",
                 valueErrors, protocolErrors, timedOut, storesSeen, storeAddress.size());
        if (valueErrors == 0 && protocolErrors == 0 && !timedOut) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+.
isaPkg.sv
busPkg.sv
regBank.sv
aluUnit.sv
instrDecoder.sv
busMaster.sv
coreSequencer.sv
cpuCore.sv
tbCpuCore.sv

/* build.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tbCpuCore -o simCpuCore

simOutput=$(./obj_dir/simCpuCore)
echo "$simOutput"

if echo "$simOutput" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1
